// ==== logic/eth_gen_pkg.sv ====
// eth_gen_pkg: shared widths, frame sizes and CRC-32 constants for the frame generator

package eth_gen_pkg;

   // ----------------------------------------
   // data types
   // ----------------------------------------
   typedef logic [7:0]  octet_t;    // one frame byte
   typedef logic [31:0] word_t;     // one client word
   typedef logic [47:0] mac_addr_t; // dst / src address
   typedef logic [15:0] len_t;      // length, type or gap
   typedef logic [1:0]  empty_t;    // unused bytes in eop word
   typedef logic [31:0] fcs_t;      // crc register

   // ----------------------------------------
   // frame layout
   // ----------------------------------------
   localparam len_t HEADER_BYTES   = 16'd14; // dst + src + len/type
   localparam len_t MIN_DATA_BYTES = 16'd60; // pad target, fcs excluded
   localparam int   FCS_BYTES      = 4;
   localparam int   WORD_BYTES     = 4;      // bytes per dout word

   // ----------------------------------------
   // crc-32, lsb first form
   // ----------------------------------------
   localparam fcs_t CRC_POLY = 32'hEDB8_8320; // 0x04c11db7 bit reversed
   localparam fcs_t CRC_INIT = 32'hFFFF_FFFF;

endpackage

// ==== logic/byte_stream_if.sv ====
// byte_stream_if: octet stream between generator stages, valid/ready with end of frame flag
`timescale 1ns/1ns

interface byte_stream_if import eth_gen_pkg::*; ();

   octet_t data;  // frame byte
   logic   valid; // data holds until taken
   logic   ready; // sink can take a byte
   logic   last;  // final byte of frame

   // producer side
   modport src (
      output data,
      output valid,
      output last,
      input  ready
   );

   // consumer side
   modport snk (
      input  data,
      input  valid,
      input  last,
      output ready
   );

endinterface

// ==== logic/frame_control.sv ====
// frame_control: accepts start, holds done low per frame and times the inter-packet gap
`timescale 1ns/1ns

module frame_control import eth_gen_pkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic start,     // request a frame
   input  len_t ipg_len,   // gap in bytes
   input  logic frame_end, // eop word taken
   output logic frame_go,  // one cycle, fields captured
   output logic done       // ready for next start
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUSY,
      ST_GAP
   } ctrl_state_t;

   ctrl_state_t state;
   len_t        gap_cnt;   // remaining gap words minus one
   logic [16:0] gap_sum;   // ipg_len + 3, no overflow
   len_t        gap_load;

   // gap in words, rounded up, never below one
   assign gap_sum  = {1'b0, ipg_len} + 17'd3;
   assign gap_load = (gap_sum[16:2] == 15'd0) ? 16'd0 : {1'b0, gap_sum[16:2]} - 16'd1;

   // ----------------------------------------
   // frame / gap sequencing
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= ST_IDLE;
         gap_cnt  <= '0;
         frame_go <= 1'b0;
         done     <= 1'b1; // idle after reset
      end
      else
      begin
         frame_go <= 1'b0;
         case (state)
            ST_IDLE:
            begin
               if (start && done)
               begin
                  frame_go <= 1'b1;
                  done     <= 1'b0;
                  gap_cnt  <= gap_load; // ipg sampled at accept
                  state    <= ST_BUSY;
               end
            end
            ST_BUSY:
            begin
               if (frame_end)
                  state <= ST_GAP; // gap starts after eop
            end
            ST_GAP:
            begin
               if (gap_cnt == '0)
               begin
                  done  <= 1'b1;
                  state <= ST_IDLE;
               end
               else
                  gap_cnt <= gap_cnt - 16'd1;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

endmodule

// ==== logic/frame_byte_gen.sv ====
// frame_byte_gen: emits header, counting payload and zero pad bytes of one frame
`timescale 1ns/1ns

module frame_byte_gen import eth_gen_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          frame_go,    // capture fields, start frame
   input  mac_addr_t     dst,
   input  mac_addr_t     src,
   input  len_t          len,         // payload bytes
   input  len_t          frmtype,     // nonzero replaces len
   input  octet_t        cntstart,    // first payload byte
   input  octet_t        cntstep,     // payload increment
   input  logic          payload_err, // corrupt last payload byte
   input  logic          pad_en,      // pad to minimum size
   byte_stream_if.src    bytes
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HDR,
      ST_PAY,
      ST_PAD
   } gen_state_t;

   gen_state_t                  state, nxt_state;
   logic [HEADER_BYTES*8-1:0]   hdr_q;      // header, next byte on top
   octet_t                      cnt;        // running payload value
   octet_t                      step_q;
   len_t                        idx;        // byte index in frame
   len_t                        pay_end_q;  // index of last payload byte
   len_t                        last_idx_q; // index of last data byte
   logic                        perr_q;
   len_t                        data_len, frame_len, type_sel;
   octet_t                      nxt_data;
   logic                        nxt_last;
   logic                        emit;       // load a new byte

   // address bytes leave low byte first
   function automatic mac_addr_t mac_wire_order(input mac_addr_t a);
      return {a[7:0], a[15:8], a[23:16], a[31:24], a[39:32], a[47:40]};
   endfunction

   assign type_sel  = (frmtype != '0) ? frmtype : len;
   assign data_len  = HEADER_BYTES + len;
   assign frame_len = (pad_en && data_len < MIN_DATA_BYTES) ? MIN_DATA_BYTES : data_len;

   assign emit = (state != ST_IDLE) && (!bytes.valid || bytes.ready);

   // ----------------------------------------
   // next byte and state
   // ----------------------------------------
   always_comb
   begin
      nxt_data  = 8'h00;
      nxt_state = state;
      nxt_last  = (idx == last_idx_q);
      case (state)
         ST_HDR:
         begin
            nxt_data = hdr_q[HEADER_BYTES*8-1 -: 8];
            if (idx == HEADER_BYTES - 16'd1)
               nxt_state = (pay_end_q != idx) ? ST_PAY : ST_PAD; // len 0 skips payload
         end
         ST_PAY:
         begin
            nxt_data = cnt ^ {8{perr_q && idx == pay_end_q}};
            if (idx == pay_end_q)
               nxt_state = ST_PAD;
         end
         default:
            nxt_data = 8'h00; // pad bytes
      endcase
      if (nxt_last)
         nxt_state = ST_IDLE;
   end

   // control, one byte in flight
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state       <= ST_IDLE;
         bytes.valid <= 1'b0;
         bytes.last  <= 1'b0;
      end
      else
      begin
         if (frame_go)
            state <= ST_HDR;
         else if (emit)
            state <= nxt_state;
         if (emit)
         begin
            bytes.valid <= 1'b1;
            bytes.last  <= nxt_last;
         end
         else if (bytes.ready)
            bytes.valid <= 1'b0; // byte taken, nothing new
      end
   end

   // ----------------------------------------
   // captured fields and byte datapath
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (frame_go)
      begin
         hdr_q      <= {mac_wire_order(dst), mac_wire_order(src), type_sel};
         cnt        <= cntstart;
         step_q     <= cntstep;
         perr_q     <= payload_err;
         pay_end_q  <= data_len - 16'd1;
         last_idx_q <= frame_len - 16'd1;
         idx        <= '0;
      end
      else if (emit)
      begin
         bytes.data <= nxt_data;
         idx        <= idx + 16'd1;
         if (state == ST_HDR)
            hdr_q <= hdr_q << 8;
         if (state == ST_PAY)
            cnt <= cnt + step_q; // wraps mod 256
      end
   end

endmodule

// ==== logic/fcs_append.sv ====
// fcs_append: forwards frame bytes, runs CRC-32 and appends the four FCS bytes
`timescale 1ns/1ns

module fcs_append import eth_gen_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       crc_err,  // corrupt whole fcs
   byte_stream_if.snk data_in,
   byte_stream_if.src data_out
);

   typedef enum logic {
      ST_DATA,
      ST_FCS
   } fcs_state_t;

   fcs_state_t  state;
   fcs_t        crc;       // running crc, reflected
   logic [1:0]  fcs_cnt;   // fcs byte index, low byte first
   logic        in_frame;  // cleared after last data byte
   logic        crc_err_q;
   logic        in_xfer;
   logic        out_free;  // output register can load
   octet_t      fcs_byte;

   // one data byte through the lsb first crc
   function automatic fcs_t crc_byte(input fcs_t c, input octet_t d);
      fcs_t r;
      r = c;
      for (int i = 0; i < 8; i++)
         r = (r >> 1) ^ (CRC_POLY & {32{r[0] ^ d[i]}});
      return r;
   endfunction

   assign out_free      = !data_out.valid || data_out.ready;
   assign data_in.ready = (state == ST_DATA) && out_free; // stalls during fcs
   assign in_xfer       = data_in.valid && data_in.ready;
   assign fcs_byte      = ~crc[{fcs_cnt, 3'b000} +: 8] ^ {8{crc_err_q}};

   // ----------------------------------------
   // pass through, then fcs
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state          <= ST_DATA;
         fcs_cnt        <= '0;
         in_frame       <= 1'b0;
         data_out.valid <= 1'b0;
         data_out.last  <= 1'b0;
      end
      else
      begin
         if (in_xfer)
         begin
            data_out.valid <= 1'b1;
            data_out.last  <= 1'b0; // last moves to fcs
            in_frame       <= !data_in.last;
            if (data_in.last)
            begin
               state   <= ST_FCS;
               fcs_cnt <= '0;
            end
         end
         else if (state == ST_FCS && out_free)
         begin
            data_out.valid <= 1'b1;
            data_out.last  <= (fcs_cnt == 2'(FCS_BYTES - 1));
            fcs_cnt        <= fcs_cnt + 2'd1;
            if (fcs_cnt == 2'(FCS_BYTES - 1))
               state <= ST_DATA;
         end
         else if (data_out.ready)
            data_out.valid <= 1'b0;
      end
   end

   // crc and byte payload
   always_ff @(posedge clk)
   begin
      if (in_xfer)
      begin
         data_out.data <= data_in.data;
         crc           <= crc_byte(in_frame ? crc : CRC_INIT, data_in.data); // seed on first
         if (!in_frame)
            crc_err_q <= crc_err;
      end
      else if (state == ST_FCS && out_free)
         data_out.data <= fcs_byte;
   end

endmodule

// ==== logic/word_packer.sv ====
// word_packer: collects octets into big-endian 32-bit words with sop, eop and tmod
`timescale 1ns/1ns

module word_packer import eth_gen_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   byte_stream_if.snk bytes,
   output word_t      dout,
   output logic       valid,
   output logic       sop,       // first word of frame
   output logic       eop,       // last word of frame
   output empty_t     tmod,      // unused low bytes on eop
   input  logic       ready,
   output logic       frame_end  // eop word taken this cycle
);

   word_t      acc;        // partial word, newest byte low
   logic [1:0] cnt;        // bytes already in acc
   logic       first_word; // next word opens a frame
   logic       byte_xfer;
   logic       load;       // word complete, move to output
   word_t      word_nxt;

   // output slot must be free to take a byte
   assign bytes.ready = !valid || ready;
   assign byte_xfer   = bytes.valid && bytes.ready;
   assign load        = byte_xfer && (cnt == 2'(WORD_BYTES - 1) || bytes.last);
   assign frame_end   = valid && ready && eop;

   // left align, first byte into 31:24, zero fill
   always_comb
   begin
      case (cnt)
         2'd0:    word_nxt = {bytes.data, 24'h000000};
         2'd1:    word_nxt = {acc[7:0], bytes.data, 16'h0000};
         2'd2:    word_nxt = {acc[15:0], bytes.data, 8'h00};
         default: word_nxt = {acc[23:0], bytes.data};
      endcase
   end

   // ----------------------------------------
   // byte count and output flags
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         cnt        <= '0;
         first_word <= 1'b1;
         valid      <= 1'b0;
         sop        <= 1'b0;
         eop        <= 1'b0;
         tmod       <= '0;
      end
      else
      begin
         if (byte_xfer)
            cnt <= bytes.last ? 2'd0 : cnt + 2'd1; // wraps after four
         if (load)
         begin
            valid      <= 1'b1;
            sop        <= first_word;
            eop        <= bytes.last;
            tmod       <= bytes.last ? 2'(WORD_BYTES - 1) - cnt : 2'd0;
            first_word <= bytes.last; // rearm for next frame
         end
         else if (ready)
         begin
            valid <= 1'b0;
            sop   <= 1'b0;
            eop   <= 1'b0;
            tmod  <= '0;
         end
      end
   end

   // word data
   always_ff @(posedge clk)
   begin
      if (byte_xfer)
         acc <= {acc[23:0], bytes.data};
      if (load)
         dout <= word_nxt;
   end

endmodule

// ==== logic/eth_gen_top.sv ====
// eth_gen_top: Ethernet frame generator, control plus byte, FCS and word stages
`timescale 1ns/1ns

module eth_gen_top import eth_gen_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  mac_addr_t dst,
   input  mac_addr_t src,
   input  len_t      len,
   input  len_t      frmtype,
   input  octet_t    cntstart,
   input  octet_t    cntstep,
   input  len_t      ipg_len,
   input  logic      payload_err,
   input  logic      crc_err,
   input  logic      pad_en,
   input  logic      start,
   input  logic      ready,
   output word_t     dout,
   output logic      valid,
   output logic      sop,
   output logic      eop,
   output empty_t    tmod,
   output logic      done
);

   logic frame_go;  // fields captured
   logic frame_end; // eop word out

   byte_stream_if gen_bytes ();  // header/payload/pad stream
   byte_stream_if fcs_bytes ();  // same plus fcs

   // ----------------------------------------
   // control
   // ----------------------------------------
   frame_control u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .ipg_len   (ipg_len),
      .frame_end (frame_end),
      .frame_go  (frame_go),
      .done      (done)
   );

   // ----------------------------------------
   // byte chain
   // ----------------------------------------
   frame_byte_gen u_gen (
      .clk         (clk),
      .reset       (reset),
      .frame_go    (frame_go),
      .dst         (dst),
      .src         (src),
      .len         (len),
      .frmtype     (frmtype),
      .cntstart    (cntstart),
      .cntstep     (cntstep),
      .payload_err (payload_err),
      .pad_en      (pad_en),
      .bytes       (gen_bytes.src)
   );

   fcs_append u_fcs (
      .clk      (clk),
      .reset    (reset),
      .crc_err  (crc_err),
      .data_in  (gen_bytes.snk),
      .data_out (fcs_bytes.src)
   );

   word_packer u_pack (
      .clk       (clk),
      .reset     (reset),
      .bytes     (fcs_bytes.snk),
      .dout      (dout),
      .valid     (valid),
      .sop       (sop),
      .eop       (eop),
      .tmod      (tmod),
      .ready     (ready),
      .frame_end (frame_end)
   );

endmodule

// ==== dv/frame_model.svh ====
// frame_model: expected byte list, FCS and word layout of one generated frame
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

octet_t exp_bytes[$]; // whole frame, fcs at the end

// plain bitwise crc-32, reflected, over the bytes built so far
function automatic fcs_t crc32_of_bytes();
   fcs_t c;
   c = 32'hFFFF_FFFF;
   foreach (exp_bytes[k])
   begin
      c = c ^ {24'h000000, exp_bytes[k]};
      for (int b = 0; b < 8; b++)
         c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
   end
   return c;
endfunction

function automatic void build_frame(input mac_addr_t d, input mac_addr_t s, input len_t l,
                                    input len_t ftype, input octet_t c0, input octet_t stp,
                                    input logic perr, input logic cerr, input logic pad);
   len_t   typ;
   octet_t pb;
   fcs_t   fcs;
   exp_bytes.delete();
   for (int i = 0; i < 6; i++)
      exp_bytes.push_back(d[8*i +: 8]); // addresses go out low byte first
   for (int i = 0; i < 6; i++)
      exp_bytes.push_back(s[8*i +: 8]);
   typ = (ftype != 16'h0000) ? ftype : l;
   exp_bytes.push_back(typ[15:8]);      // type field, network order
   exp_bytes.push_back(typ[7:0]);
   for (int i = 0; i < int'(l); i++)
   begin
      pb = 8'(int'(c0) + i * int'(stp)); // counting payload mod 256
      if (perr && i == int'(l) - 1)
         pb = ~pb;
      exp_bytes.push_back(pb);
   end
   while (pad && exp_bytes.size() < 60)
      exp_bytes.push_back(8'h00);
   fcs = ~crc32_of_bytes();
   if (cerr)
      fcs = ~fcs;
   for (int i = 0; i < 4; i++)
      exp_bytes.push_back(fcs[8*i +: 8]); // fcs low byte first
endfunction

// word w of the frame, first byte in 31:24, zero fill past the end
function automatic word_t exp_word(input int w);
   word_t r;
   r = '0;
   for (int b = 0; b < 4; b++)
      if (4 * w + b < exp_bytes.size())
         r[31 - 8*b -: 8] = exp_bytes[4 * w + b];
   return r;
endfunction

`endif

// ==== dv/tb_eth_gen.sv ====
// tb_eth_gen: directed tests of the Ethernet frame generator against a byte level model
`timescale 1ns/1ns

module tb_eth_gen import eth_gen_pkg::*; ();

   `include "frame_model.svh"

   localparam int MAX_CYCLES = 20000; // all tests need roughly 2500

   logic      clk, reset, start, ready, payload_err, crc_err, pad_en;
   mac_addr_t dst, src;
   len_t      len, frmtype, ipg_len;
   octet_t    cntstart, cntstep;
   word_t     dout;
   logic      valid, sop, eop, done;
   empty_t    tmod;
   int        err_cnt, fail_cnt, cycle_cnt, seed;

   eth_gen_top UUT (
      .clk(clk), .reset(reset), .dst(dst), .src(src), .len(len), .frmtype(frmtype),
      .cntstart(cntstart), .cntstep(cntstep), .ipg_len(ipg_len),
      .payload_err(payload_err), .crc_err(crc_err), .pad_en(pad_en), .start(start),
      .ready(ready), .dout(dout), .valid(valid), .sop(sop), .eop(eop), .tmod(tmod),
      .done(done)
   );

   always #50 clk = ~clk; // 100 ns period

   // ----------------------------------------
   // timeout and checks
   // ----------------------------------------
   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic set_frame(input len_t l, input len_t ftype, input logic pad,
                            input logic perr, input logic cerr, input len_t ipg);
      len         = l;
      frmtype     = ftype;
      pad_en      = pad;
      payload_err = perr;
      crc_err     = cerr;
      ipg_len     = ipg;
   endtask

   // start one frame, collect words to eop, then time the gap
   task automatic run_frame(input logic bp);
      int     w, nwords, edges, exp_gap, last_mod;
      logic   got_eop, hold, is_last;
      word_t  prev_dout;
      logic   prev_sop, prev_eop;
      empty_t prev_tmod;
      build_frame(dst, src, len, frmtype, cntstart, cntstep, payload_err, crc_err, pad_en);
      nwords   = (exp_bytes.size() + 3) / 4;
      last_mod = (4 - exp_bytes.size() % 4) % 4; // unused bytes in eop word
      exp_gap  = (int'(ipg_len) + 3) / 4;
      if (exp_gap == 0)
         exp_gap = 1;
      while (!done)
         @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_val("done", 32'(done), 32'd0); // low once accepted
      w       = 0;
      got_eop = 1'b0;
      hold    = 1'b0;
      while (!got_eop)
      begin
         if (hold) // stalled word must not move
         begin
            check_val("valid held", 32'(valid), 32'd1);
            check_val("dout held", dout, prev_dout);
            check_val("sop held", 32'(sop), 32'(prev_sop));
            check_val("eop held", 32'(eop), 32'(prev_eop));
            check_val("tmod held", 32'(tmod), 32'(prev_tmod));
         end
         start = (w == 2); // busy, ignored
         ready = bp ? (($random(seed) & 3) != 0) : 1'b1;
         hold      = valid && !ready;
         prev_dout = dout;
         prev_sop  = sop;
         prev_eop  = eop;
         prev_tmod = tmod;
         if (valid && ready)
         begin
            is_last = (w == nwords - 1);
            check_val("dout", dout, exp_word(w));
            check_val("sop", 32'(sop), 32'(w == 0));
            check_val("eop", 32'(eop), 32'(is_last));
            check_val("tmod", 32'(tmod), is_last ? 32'(last_mod) : 32'd0);
            got_eop = eop;
            w++;
            if (!got_eop && w >= nwords)
            begin
               fail_cnt++;
               $display("frame longer than expected, no eop after %0d words", nwords);
               got_eop = 1'b1;
            end
         end
         @(negedge clk);
      end
      ready = 1'b1;
      edges = 0;
      while (!done && edges < 1000)
      begin
         start = (edges == 0); // inside the gap, ignored
         @(negedge clk);
         edges++;
      end
      start = 1'b0;
      check_val("gap cycles", 32'(edges), 32'(exp_gap));
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic test_normal_and_length();
      dst      = 48'h0a1b_2c3d_4e5f;
      src      = 48'h0012_3456_789a;
      cntstart = 8'h00;
      cntstep  = 8'h01;
      set_frame(16'd46, 16'h0000, 1'b1, 1'b0, 1'b0, 16'd12); // 64 bytes, tmod 0
      run_frame(1'b0);
      cntstart = 8'hf0;
      cntstep  = 8'h11; // wraps mod 256
      set_frame(16'd3, 16'h0000, 1'b1, 1'b0, 1'b0, 16'd4);   // padded to 64
      run_frame(1'b0);
      set_frame(16'd3, 16'h0000, 1'b0, 1'b0, 1'b0, 16'd4);   // 21 bytes, tmod 3
      run_frame(1'b0);
      for (int l = 5; l <= 7; l++)
      begin
         set_frame(16'(l), 16'h0000, 1'b0, 1'b0, 1'b0, 16'd8); // tmod 1, 0, 3
         run_frame(1'b0);
      end
   endtask

   task automatic test_type_and_errors();
      set_frame(16'd20, 16'h0800, 1'b1, 1'b0, 1'b0, 16'd12); // type replaces len
      run_frame(1'b0);
      set_frame(16'd50, 16'h88b5, 1'b0, 1'b0, 1'b0, 16'd12);
      run_frame(1'b0);
      set_frame(16'd30, 16'h0000, 1'b1, 1'b1, 1'b0, 16'd12); // bad last payload byte
      run_frame(1'b0);
      set_frame(16'd40, 16'h0000, 1'b0, 1'b0, 1'b1, 16'd12); // inverted fcs
      run_frame(1'b0);
      set_frame(16'd7, 16'h0000, 1'b0, 1'b1, 1'b1, 16'd12);  // both at once
      run_frame(1'b0);
   endtask

   task automatic test_backpressure_and_gap();
      cntstep = 8'h07;
      set_frame(16'd1000, 16'h0000, 1'b1, 1'b0, 1'b0, 16'd12); // random ready
      run_frame(1'b1);
      set_frame(16'd10, 16'h0000, 1'b0, 1'b0, 1'b0, 16'd12);   // gap of 3
      run_frame(1'b0);
      set_frame(16'd46, 16'h0000, 1'b0, 1'b0, 1'b0, 16'd1);    // gap of 1
      run_frame(1'b0);
      repeat (20) // no frame from the ignored starts
      begin
         @(negedge clk);
         check_val("valid idle", 32'(valid), 32'd0);
         check_val("done idle", 32'(done), 32'd1);
      end
   endtask

   initial
   begin
      clk       = 1'b0;
      reset     = 1'b1;
      start     = 1'b0;
      ready     = 1'b1;
      dst       = '0;
      src       = '0;
      cntstart  = '0;
      cntstep   = '0;
      set_frame(16'd0, 16'h0000, 1'b0, 1'b0, 1'b0, 16'd12);
      seed      = 32'h91a50f6d;
      err_cnt   = 0;
      fail_cnt  = 0;
      cycle_cnt = 0;
      repeat (8)
         @(negedge clk);
      reset = 1'b0;
      check_val("done", 32'(done), 32'd1); // high after reset
      check_val("valid", 32'(valid), 32'd0);
      test_normal_and_length();
      test_type_and_errors();
      test_backpressure_and_gap();
      $display("summary: %0d value errors, %0d other errors", err_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+dv
logic/eth_gen_pkg.sv
logic/byte_stream_if.sv
logic/frame_control.sv
logic/frame_byte_gen.sv
logic/fcs_append.sv
logic/word_packer.sv
logic/eth_gen_top.sv
dv/tb_eth_gen.sv

// ==== run.sh ====
#!/bin/sh
# build the frame generator testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f project.f \
   --top-module tb_eth_gen --Mdir obj_dir -o tb_eth_gen
./obj_dir/tb_eth_gen > sim.log
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
